/* common/idiv_pkg.sv */
// integer divider shared types
`default_nettype none

package idiv_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int idiv_width_c   = 32;
  // shift amounts run 0 to 32, plus 33 inside the align shifter
  localparam int idiv_shift_w_c = 6;

  // one-hot operand selects, bit n enables mux input n
  localparam logic [1:0] opa_sel_req_c   = 2'b01;
  localparam logic [1:0] opa_sel_add_c   = 2'b10;
  localparam logic [2:0] opb_sel_opc_c   = 3'b001;
  localparam logic [2:0] opb_sel_add_c   = 3'b010;
  localparam logic [2:0] opb_sel_shift_c = 3'b100;
  localparam logic [2:0] opc_sel_req_c   = 3'b001;
  localparam logic [2:0] opc_sel_add_c   = 3'b010;
  localparam logic [2:0] opc_sel_shift_c = 3'b100;

  // --------------------
  // request and response
  // --------------------
  typedef struct packed {
    logic [idiv_width_c-1:0] dividend;
    logic [idiv_width_c-1:0] divisor;
    logic                    signed_div;
  } idiv_req_t;

  typedef struct packed {
    logic [idiv_width_c-1:0] quotient;
    logic [idiv_width_c-1:0] remainder;
  } idiv_resp_t;

  // controller to datapath
  typedef struct packed {
    logic [1:0]                opa_sel;
    logic [2:0]                opb_sel;
    logic [2:0]                opc_sel;
    logic                      opa_ld;
    logic                      opb_ld;
    logic                      opc_ld;
    logic                      opa_inv;
    logic                      opb_inv;
    logic                      opa_clr_n;
    logic                      opb_clr_n;
    logic                      adder_cin;
    logic                      latch_req;
    logic [idiv_shift_w_c-1:0] shift_val;
  } idiv_ctrl_t;

  // datapath to controller
  typedef struct packed {
    logic                      zero_divisor;
    logic                      signed_div_r;
    logic                      adder_neg;
    logic                      opa_neg;
    logic                      opc_neg;
    logic [idiv_shift_w_c-1:0] div_shift;
  } idiv_stat_t;

endpackage

`default_nettype wire

/* verilog/idiv_clz.sv */
// leading zero counter
`timescale 1ns/1ps
`default_nettype none

module idiv_clz import idiv_pkg::*; (
  input  logic [idiv_width_c-1:0]   a_i,
  output logic [idiv_shift_w_c-1:0] num_zero_o
);

  // --------------------
  // priority encode from the msb
  // --------------------
  // scan upward so the highest set bit is the last one to write
  always_comb begin
    num_zero_o = idiv_shift_w_c'(idiv_width_c);
    for (int i = 0; i < idiv_width_c; i++) begin
      if (a_i[i]) begin
        num_zero_o = idiv_shift_w_c'(idiv_width_c - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

/* idiv/idiv_datapath.sv */
// divider datapath
`timescale 1ns/1ps
`default_nettype none

module idiv_datapath import idiv_pkg::*; (
  input  logic                      clk_i,
  input  idiv_req_t                 req_i,
  input  logic [idiv_shift_w_c-1:0] dividend_zeros_i,
  input  logic [idiv_shift_w_c-1:0] divisor_zeros_i,
  input  idiv_ctrl_t                ctrl_i,
  output idiv_stat_t                stat_o,
  output idiv_resp_t                resp_o
);

  localparam int opw_c = idiv_width_c + 1;

  // operand registers, one guard bit above the word
  logic [idiv_width_c:0] opa_r;
  logic [idiv_width_c:0] opb_r;
  logic [idiv_width_c:0] opc_r;
  logic [idiv_width_c:0] opa_mux;
  logic [idiv_width_c:0] opb_mux;
  logic [idiv_width_c:0] opc_mux;
  logic                  signed_div_r;
  logic                  zero_div_r;

  logic                  req_dvs_neg;
  logic                  req_dvd_neg;
  logic                  req_zero_div;
  logic [idiv_width_c:0] req_dvs_ext;
  logic [idiv_width_c:0] req_dvd_ext;

  logic [idiv_width_c:0] add_in0;
  logic [idiv_width_c:0] add_in1;
  logic [idiv_width_c:0] add_res;

  logic [idiv_shift_w_c-1:0] shr_amt;
  logic [idiv_shift_w_c-1:0] shl_amt;
  logic [idiv_shift_w_c-1:0] qbit_amt;
  logic [idiv_width_c:0]     qbit;
  logic [idiv_width_c:0]     shift_b;
  logic [idiv_width_c:0]     shift_c;

  logic [idiv_shift_w_c-1:0] dvd_zeros;
  logic [idiv_shift_w_c-1:0] dvs_zeros;
  logic [idiv_shift_w_c-1:0] div_shift;

  // --------------------
  // request operands
  // --------------------
  assign req_dvs_neg  = req_i.signed_div & req_i.divisor[idiv_width_c-1];
  assign req_dvd_neg  = req_i.signed_div & req_i.dividend[idiv_width_c-1];
  assign req_zero_div = ~|req_i.divisor;
  assign req_dvs_ext  = {req_dvs_neg, req_i.divisor};
  assign req_dvd_ext  = {req_dvd_neg, req_i.dividend};

  // alignment amount
  // a negative operand gives no useful raw count, so fall back to safe bounds
  assign dvd_zeros = req_dvd_neg ? '0 : dividend_zeros_i;
  assign dvs_zeros = req_dvs_neg ? idiv_shift_w_c'(idiv_width_c - 1) : divisor_zeros_i;

  always_comb begin
    if (req_zero_div) begin
      div_shift = idiv_shift_w_c'(idiv_width_c - 1);
    end else if (dvs_zeros < dvd_zeros) begin
      // divisor larger than dividend, one step is enough
      div_shift = '0;
    end else begin
      div_shift = dvs_zeros - dvd_zeros;
    end
  end

  // --------------------
  // adder
  // --------------------
  assign add_in0 = (opa_r ^ {opw_c{ctrl_i.opa_inv}}) & {opw_c{ctrl_i.opa_clr_n}};
  assign add_in1 = (opb_r ^ {opw_c{ctrl_i.opb_inv}}) & {opw_c{ctrl_i.opb_clr_n}};
  assign add_res = add_in0 + add_in1 + opw_c'(ctrl_i.adder_cin);

  // shifter shared by align and iterate
  // shift_val of 32 is one plain iteration step, smaller values pre-align C
  assign shr_amt  = ctrl_i.shift_val;
  assign shl_amt  = idiv_shift_w_c'(idiv_width_c + 1) - ctrl_i.shift_val;
  assign qbit_amt = idiv_shift_w_c'(idiv_width_c) - ctrl_i.shift_val;
  assign qbit     = {{idiv_width_c{1'b0}}, ~add_res[idiv_width_c]};
  assign shift_b  = (add_res << shl_amt) | (opc_r >> shr_amt);
  assign shift_c  = (opc_r << shl_amt) | (qbit << qbit_amt);

  // --------------------
  // operand muxes
  // --------------------
  assign opa_mux = ({opw_c{ctrl_i.opa_sel[0]}} & req_dvs_ext)
                 | ({opw_c{ctrl_i.opa_sel[1]}} & add_res);

  assign opb_mux = ({opw_c{ctrl_i.opb_sel[0]}} & opc_r)
                 | ({opw_c{ctrl_i.opb_sel[1]}} & add_res)
                 | ({opw_c{ctrl_i.opb_sel[2]}} & shift_b);

  assign opc_mux = ({opw_c{ctrl_i.opc_sel[0]}} & req_dvd_ext)
                 | ({opw_c{ctrl_i.opc_sel[1]}} & add_res)
                 | ({opw_c{ctrl_i.opc_sel[2]}} & shift_c);

  always_ff @(posedge clk_i) begin
    if (ctrl_i.opa_ld) begin
      opa_r <= opa_mux;
    end
    if (ctrl_i.opb_ld) begin
      opb_r <= opb_mux;
    end
    if (ctrl_i.opc_ld) begin
      opc_r <= opc_mux;
    end
    if (ctrl_i.latch_req) begin
      signed_div_r <= req_i.signed_div;
      zero_div_r   <= req_zero_div;
    end
  end

  // --------------------
  // status and result
  // --------------------
  assign stat_o = '{
    zero_divisor: zero_div_r,
    signed_div_r: signed_div_r,
    adder_neg:    add_res[idiv_width_c],
    opa_neg:      opa_r[idiv_width_c],
    opc_neg:      opc_r[idiv_width_c],
    div_shift:    div_shift
  };

  // remainder ends in A, quotient in C
  assign resp_o = '{
    quotient:  opc_r[idiv_width_c-1:0],
    remainder: opa_r[idiv_width_c-1:0]
  };

endmodule

`default_nettype wire

/* idiv/idiv_controller.sv */
// divider control FSM
`timescale 1ns/1ps
`default_nettype none

module idiv_controller import idiv_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       v_i,
  output logic       ready_and_o,
  input  idiv_stat_t stat_i,
  output idiv_ctrl_t ctrl_o,
  output logic       v_o,
  input  logic       yumi_i
);

  typedef enum logic [3:0] {
    idle_s,
    neg_dvs_s,
    neg_dvd_s,
    align_s,
    iter_s,
    repair_s,
    neg_rem_s,
    neg_quo_s,
    done_s
  } state_t;

  state_t                    state_r;
  state_t                    state_nxt;
  logic [idiv_shift_w_c-1:0] cnt_r;
  logic                      neg_last_r;
  logic                      dvs_neg_r;
  logic                      dvd_neg_r;
  logic                      dvs_neg;
  logic                      dvd_neg;
  logic                      last_iter;
  logic                      quo_neg;

  assign dvs_neg   = stat_i.signed_div_r & stat_i.opa_neg;
  assign dvd_neg   = stat_i.signed_div_r & stat_i.opc_neg;
  assign last_iter = (cnt_r == '0);
  // a zero divisor keeps the all ones quotient whatever the signs
  assign quo_neg   = (dvd_neg_r ^ dvs_neg_r) & ~stat_i.zero_divisor;

  assign ready_and_o = (state_r == idle_s);
  assign v_o         = (state_r == done_s);

  // --------------------
  // state and counters
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r    <= idle_s;
      cnt_r      <= '0;
      neg_last_r <= 1'b0;
      dvs_neg_r  <= 1'b0;
      dvd_neg_r  <= 1'b0;
    end else begin
      state_r <= state_nxt;
      case (state_r)
        idle_s: begin
          if (v_i) begin
            cnt_r <= stat_i.div_shift;
          end
        end
        neg_dvs_s: dvs_neg_r <= dvs_neg;
        neg_dvd_s: dvd_neg_r <= dvd_neg;
        align_s:   neg_last_r <= 1'b0;
        iter_s: begin
          neg_last_r <= stat_i.adder_neg;
          if (!last_iter) begin
            cnt_r <= cnt_r - idiv_shift_w_c'(1);
          end
        end
        default: begin
        end
      endcase
    end
  end

  // --------------------
  // next state and datapath commands
  // --------------------
  always_comb begin
    state_nxt        = state_r;
    ctrl_o           = '0;
    ctrl_o.opa_clr_n = 1'b1;
    ctrl_o.opb_clr_n = 1'b1;
    ctrl_o.shift_val = idiv_shift_w_c'(idiv_width_c);

    case (state_r)
      idle_s: begin
        if (v_i) begin
          ctrl_o.latch_req = 1'b1;
          ctrl_o.opa_sel   = opa_sel_req_c;
          ctrl_o.opa_ld    = 1'b1;
          ctrl_o.opc_sel   = opc_sel_req_c;
          ctrl_o.opc_ld    = 1'b1;
          state_nxt        = neg_dvs_s;
        end
      end

      // A = -A when needed, and copy C to B for the next step
      neg_dvs_s: begin
        ctrl_o.opa_inv   = 1'b1;
        ctrl_o.opb_clr_n = 1'b0;
        ctrl_o.adder_cin = 1'b1;
        ctrl_o.opa_sel   = opa_sel_add_c;
        ctrl_o.opa_ld    = dvs_neg;
        ctrl_o.opb_sel   = opb_sel_opc_c;
        ctrl_o.opb_ld    = 1'b1;
        state_nxt        = neg_dvd_s;
      end

      neg_dvd_s: begin
        ctrl_o.opb_inv   = 1'b1;
        ctrl_o.opa_clr_n = 1'b0;
        ctrl_o.adder_cin = 1'b1;
        ctrl_o.opc_sel   = opc_sel_add_c;
        ctrl_o.opc_ld    = dvd_neg;
        state_nxt        = align_s;
      end

      // adder held at zero so the shifter only moves C
      align_s: begin
        ctrl_o.opa_clr_n = 1'b0;
        ctrl_o.opb_clr_n = 1'b0;
        ctrl_o.shift_val = cnt_r;
        ctrl_o.opb_sel   = opb_sel_shift_c;
        ctrl_o.opb_ld    = 1'b1;
        ctrl_o.opc_sel   = opc_sel_shift_c;
        ctrl_o.opc_ld    = 1'b1;
        state_nxt        = iter_s;
      end

      // subtract after a positive result and add after a negative one
      iter_s: begin
        ctrl_o.opa_inv   = ~neg_last_r;
        ctrl_o.adder_cin = ~neg_last_r;
        ctrl_o.opb_sel   = last_iter ? opb_sel_add_c : opb_sel_shift_c;
        ctrl_o.opb_ld    = 1'b1;
        ctrl_o.opc_sel   = opc_sel_shift_c;
        ctrl_o.opc_ld    = 1'b1;
        if (last_iter) begin
          state_nxt = repair_s;
        end
      end

      // move the remainder into A and add the divisor back if it went negative
      repair_s: begin
        ctrl_o.opa_clr_n = neg_last_r;
        ctrl_o.opa_sel   = opa_sel_add_c;
        ctrl_o.opa_ld    = 1'b1;
        state_nxt        = neg_rem_s;
      end

      neg_rem_s: begin
        ctrl_o.opa_inv   = 1'b1;
        ctrl_o.opb_clr_n = 1'b0;
        ctrl_o.adder_cin = 1'b1;
        ctrl_o.opa_sel   = opa_sel_add_c;
        ctrl_o.opa_ld    = dvd_neg_r;
        ctrl_o.opb_sel   = opb_sel_opc_c;
        ctrl_o.opb_ld    = 1'b1;
        state_nxt        = neg_quo_s;
      end

      neg_quo_s: begin
        ctrl_o.opb_inv   = 1'b1;
        ctrl_o.opa_clr_n = 1'b0;
        ctrl_o.adder_cin = 1'b1;
        ctrl_o.opc_sel   = opc_sel_add_c;
        ctrl_o.opc_ld    = quo_neg;
        state_nxt        = done_s;
      end

      // hold the result until it is taken
      done_s: begin
        if (yumi_i) begin
          state_nxt = idle_s;
        end
      end

      default: state_nxt = idle_s;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/idiv_top.sv */
// iterative integer divider
`timescale 1ns/1ps
`default_nettype none

module idiv_top import idiv_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  logic       v_i,
  output logic       ready_and_o,
  input  idiv_req_t  req_i,

  output logic       v_o,
  input  logic       yumi_i,
  output idiv_resp_t resp_o
);

  logic [idiv_shift_w_c-1:0] dividend_zeros;
  logic [idiv_shift_w_c-1:0] divisor_zeros;
  idiv_ctrl_t                ctrl;
  idiv_stat_t                stat;

  // --------------------
  // leading zero counts of the raw request
  // --------------------
  idiv_clz u_dividend_clz (
    .a_i        (req_i.dividend),
    .num_zero_o (dividend_zeros)
  );

  idiv_clz u_divisor_clz (
    .a_i        (req_i.divisor),
    .num_zero_o (divisor_zeros)
  );

  idiv_datapath u_datapath (
    .clk_i            (clk_i),
    .req_i            (req_i),
    .dividend_zeros_i (dividend_zeros),
    .divisor_zeros_i  (divisor_zeros),
    .ctrl_i           (ctrl),
    .stat_o           (stat),
    .resp_o           (resp_o)
  );

  idiv_controller u_controller (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (v_i),
    .ready_and_o (ready_and_o),
    .stat_i      (stat),
    .ctrl_o      (ctrl),
    .v_o         (v_o),
    .yumi_i      (yumi_i)
  );

endmodule

`default_nettype wire

/* tb/idiv_tb.sv */
// integer divider testbench
`timescale 1ns/1ps
`default_nettype none

module idiv_tb import idiv_pkg::*; ();

  // divisions issued over the whole run, one per request
  localparam int num_ops_c     = 1 + 20 + 8 + 6 + 2 + 4;
  localparam int op_limit_c    = 60;
  localparam int cycle_limit_c = op_limit_c * num_ops_c;

  logic       clk_i;
  logic       arst_n_i;
  logic       v_i;
  logic       ready_and_o;
  idiv_req_t  req_i;
  logic       v_o;
  logic       yumi_i;
  idiv_resp_t resp_o;

  int     err_cnt;
  int     chk_cnt;
  int     test_cnt;
  int     cycle_cnt;
  integer seed;

  idiv_top i_dut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (v_i),
    .ready_and_o (ready_and_o),
    .req_i       (req_i),
    .v_o         (v_o),
    .yumi_i      (yumi_i),
    .resp_o      (resp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit_c) begin
      $display("run stopped after %0d cycles without finishing", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // --------------------
  // reference model
  // --------------------
  // signed results truncate toward zero, remainder follows the dividend
  function automatic idiv_resp_t ref_div(idiv_req_t req);
    idiv_resp_t              res;
    logic                    a_neg;
    logic                    b_neg;
    logic [idiv_width_c-1:0] a_mag;
    logic [idiv_width_c-1:0] b_mag;
    logic [idiv_width_c-1:0] q_mag;
    logic [idiv_width_c-1:0] r_mag;
    a_neg = req.signed_div & req.dividend[idiv_width_c-1];
    b_neg = req.signed_div & req.divisor[idiv_width_c-1];
    if (req.divisor == '0) begin
      res.quotient  = '1;
      res.remainder = req.dividend;
    end else begin
      a_mag = a_neg ? -req.dividend : req.dividend;
      b_mag = b_neg ? -req.divisor : req.divisor;
      q_mag = a_mag / b_mag;
      r_mag = a_mag % b_mag;
      res.quotient  = (a_neg ^ b_neg) ? -q_mag : q_mag;
      res.remainder = a_neg ? -r_mag : r_mag;
    end
    return res;
  endfunction

  function automatic idiv_req_t make_req(logic [idiv_width_c-1:0] dvd,
                                         logic [idiv_width_c-1:0] dvs, logic sgn);
    idiv_req_t req;
    req.dividend   = dvd;
    req.divisor    = dvs;
    req.signed_div = sgn;
    return req;
  endfunction

  // --------------------
  // compare tasks
  // --------------------
  task automatic compare_resp(string name, idiv_resp_t got, idiv_resp_t exp);
    chk_cnt++;
    if (got.quotient !== exp.quotient) begin
      $display("Error at %0t: %s.quotient got %h expected %h",
               $time, name, got.quotient, exp.quotient);
      err_cnt++;
    end
    if (got.remainder !== exp.remainder) begin
      $display("Error at %0t: %s.remainder got %h expected %h",
               $time, name, got.remainder, exp.remainder);
      err_cnt++;
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------
  // bus tasks
  // --------------------
  task automatic apply_reset();
    @(posedge clk_i);
    arst_n_i <= 1'b0;
    v_i      <= 1'b0;
    yumi_i   <= 1'b0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
  endtask

  task automatic issue_req(idiv_req_t req);
    int n;
    n = 0;
    @(negedge clk_i);
    while (ready_and_o !== 1'b1 && n < op_limit_c) begin
      @(negedge clk_i);
      n++;
    end
    if (ready_and_o !== 1'b1) begin
      $display("DUT never became ready for a request at %0t", $time);
      err_cnt++;
    end
    @(posedge clk_i);
    v_i   <= 1'b1;
    req_i <= req;
    @(posedge clk_i);
    v_i   <= 1'b0;
  endtask

  task automatic wait_result(output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < op_limit_c) begin
      @(negedge clk_i);
      if (v_o === 1'b1) begin
        seen = 1'b1;
      end
      n++;
    end
    if (!seen) begin
      $display("no result within the limit at %0t", $time);
      err_cnt++;
    end
  endtask

  task automatic consume_resp();
    @(posedge clk_i);
    yumi_i <= 1'b1;
    @(posedge clk_i);
    yumi_i <= 1'b0;
  endtask

  task automatic run_div(idiv_req_t req);
    bit seen;
    issue_req(req);
    wait_result(seen);
    if (seen) begin
      compare_resp("resp_o", resp_o, ref_div(req));
      consume_resp();
    end
  endtask

  task automatic report_test(string name, int err_before);
    test_cnt++;
    $display("%s finished with %0d errors", name, err_cnt - err_before);
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic unsigned_division();
    int                      err_before;
    int                      sh;
    logic [idiv_width_c-1:0] dvd;
    logic [idiv_width_c-1:0] dvs;
    err_before = err_cnt;
    run_div(make_req(32'd100, 32'd7, 1'b0));
    run_div(make_req(32'd7, 32'd100, 1'b0));
    run_div(make_req(32'd12345, 32'd12345, 1'b0));
    run_div(make_req(32'hdeadbeef, 32'd1, 1'b0));
    run_div(make_req(32'hffffffff, 32'hffffffff, 1'b0));
    run_div(make_req(32'hffffffff, 32'd2, 1'b0));
    run_div(make_req(32'd0, 32'd5, 1'b0));
    run_div(make_req(32'h80000000, 32'd3, 1'b0));
    // random divisors get narrowed so that every alignment shows up
    for (int i = 0; i < 12; i++) begin
      dvd = $random(seed);
      dvs = $random(seed);
      sh  = $unsigned($random(seed)) % 32;
      dvs = dvs >> sh;
      if (dvs == '0) begin
        dvs = 32'd1;
      end
      run_div(make_req(dvd, dvs, 1'b0));
    end
    report_test("unsigned division", err_before);
  endtask

  task automatic signed_division();
    int err_before;
    err_before = err_cnt;
    run_div(make_req(32'd100, 32'd7, 1'b1));
    run_div(make_req(-32'sd100, 32'd7, 1'b1));
    run_div(make_req(32'd100, -32'sd7, 1'b1));
    run_div(make_req(-32'sd100, -32'sd7, 1'b1));
    run_div(make_req(32'd7, -32'sd100, 1'b1));
    run_div(make_req(-32'sd7, 32'd100, 1'b1));
    run_div(make_req(32'h7fffffff, 32'hffffffff, 1'b1));
    run_div(make_req(32'hffffffff, 32'h7fffffff, 1'b1));
    report_test("signed division", err_before);
  endtask

  task automatic corner_cases();
    int err_before;
    err_before = err_cnt;
    run_div(make_req(32'd5, 32'd0, 1'b0));
    run_div(make_req(32'hffffffff, 32'd0, 1'b0));
    run_div(make_req(-32'sd5, 32'd0, 1'b1));
    run_div(make_req(32'd5, 32'd0, 1'b1));
    run_div(make_req(32'd0, 32'd0, 1'b1));
    // most negative value over minus one wraps back to itself
    run_div(make_req(32'h80000000, 32'hffffffff, 1'b1));
    report_test("corner cases", err_before);
  endtask

  task automatic handshake_rules();
    int        err_before;
    int        n;
    bit        seen;
    idiv_req_t first;
    idiv_req_t other;
    err_before = err_cnt;
    first = make_req(32'd1000, 32'd9, 1'b0);
    other = make_req(32'd77, 32'd2, 1'b1);
    for (int k = 0; k < 2; k++) begin
      issue_req(first);
      seen = 1'b0;
      n    = 0;
      while (!seen && n < op_limit_c) begin
        @(negedge clk_i);
        if (v_o === 1'b1) begin
          seen = 1'b1;
        end else begin
          compare_flag("ready_and_o", ready_and_o, 1'b0);
          @(posedge clk_i);
          // pulses on odd cycles, every cycle on the second pass
          v_i   <= (k == 1) | n[0];
          req_i <= other;
        end
        n++;
      end
      if (seen) begin
        compare_flag("ready_and_o", ready_and_o, 1'b0);
        compare_resp("resp_o", resp_o, ref_div(first));
        @(posedge clk_i);
        v_i    <= 1'b0;
        yumi_i <= 1'b1;
        @(posedge clk_i);
        yumi_i <= 1'b0;
        @(negedge clk_i);
        compare_flag("ready_and_o", ready_and_o, 1'b1);
        compare_flag("v_o", v_o, 1'b0);
      end else begin
        $display("no result within the limit at %0t", $time);
        err_cnt++;
      end
    end
    report_test("handshake", err_before);
  endtask

  task automatic back_pressure();
    int         err_before;
    int         delay;
    bit         seen;
    idiv_req_t  req;
    idiv_resp_t held;
    err_before = err_cnt;
    for (int k = 0; k < 4; k++) begin
      req = make_req($random(seed), $random(seed) >> 4, k[0]);
      issue_req(req);
      wait_result(seen);
      if (seen) begin
        held = resp_o;
        compare_resp("resp_o", held, ref_div(req));
        delay = $unsigned($random(seed)) % 11;
        repeat (delay) begin
          @(negedge clk_i);
          compare_flag("v_o", v_o, 1'b1);
          compare_resp("resp_o", resp_o, held);
        end
        consume_resp();
        @(negedge clk_i);
        compare_flag("ready_and_o", ready_and_o, 1'b1);
        compare_flag("v_o", v_o, 1'b0);
      end
    end
    report_test("back-pressure", err_before);
  endtask

  task automatic reset_recovery();
    int err_before;
    err_before = err_cnt;
    issue_req(make_req(32'hcafe0000, 32'd3, 1'b0));
    repeat (5) @(posedge clk_i);
    apply_reset();
    @(negedge clk_i);
    compare_flag("ready_and_o", ready_and_o, 1'b1);
    compare_flag("v_o", v_o, 1'b0);
    report_test("reset", err_before);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    arst_n_i  = 1'b0;
    v_i       = 1'b0;
    req_i     = '0;
    yumi_i    = 1'b0;
    err_cnt   = 0;
    chk_cnt   = 0;
    test_cnt  = 0;
    cycle_cnt = 0;
    seed      = 32'hb903;

    apply_reset();
    reset_recovery();
    unsigned_division();
    signed_division();
    corner_cases();
    handshake_rules();
    back_pressure();

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
common/idiv_pkg.sv
verilog/idiv_clz.sv
idiv/idiv_datapath.sv
idiv/idiv_controller.sv
verilog/idiv_top.sv
tb/idiv_tb.sv

/* run.sh */
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module idiv_tb -f all.f -o vsim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
  echo "failures found in sim.log"
  exit 1
fi

exit 0
